// File: design/mem_pkg.sv
// Data path fixed at 32 bits with byte strobes; responses are OKAY only, no error codes

package mem_pkg;

  // --------------------------------------------------------------------------
  // Bus widths
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Address bits below the word address
  localparam int BYTE_OFFSET = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // AXI response code
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // --------------------------------------------------------------------------
  // Bank state machines
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_t;

  // Word address of a byte address; the bank index sits in its low bits
  function automatic addr_t word_addr(input addr_t byte_addr);
    return byte_addr >> BYTE_OFFSET;
  endfunction

endpackage

// File: design/axil_bank_router.sv
// NUM_BANKS and BANK_DEPTH must be powers of two, at least 2; AW and W must arrive together
`timescale 1ns/10ps

module axil_bank_router #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 64
) (
  input  logic                 i_aclk,
  input  logic                 i_rst,
  input  logic                 i_awvalid,
  output logic                 o_awready,
  input  mem_pkg::addr_t       i_awaddr,
  input  logic                 i_wvalid,
  output logic                 o_wready,
  input  mem_pkg::data_t       i_wdata,
  input  mem_pkg::strb_t       i_wstrb,
  input  logic                 i_arvalid,
  output logic                 o_arready,
  input  mem_pkg::addr_t       i_araddr,
  output logic [NUM_BANKS-1:0] o_bank_awvalid,
  input  logic [NUM_BANKS-1:0] i_bank_awready,
  output mem_pkg::addr_t       o_bank_awaddr,
  output logic [NUM_BANKS-1:0] o_bank_wvalid,
  input  logic [NUM_BANKS-1:0] i_bank_wready,
  output mem_pkg::data_t       o_bank_wdata,
  output mem_pkg::strb_t       o_bank_wstrb,
  output logic [NUM_BANKS-1:0] o_bank_arvalid,
  input  logic [NUM_BANKS-1:0] i_bank_arready,
  output mem_pkg::addr_t       o_bank_araddr,
  input  logic                 i_wr_done,
  input  logic                 i_rd_done
);

  localparam int BANK_BITS = $clog2(NUM_BANKS);
  localparam int IDX_BITS  = $clog2(BANK_DEPTH);

  localparam logic [NUM_BANKS-1:0] BANK0 = {{(NUM_BANKS-1){1'b0}}, 1'b1};

  logic                 wr_busy;
  logic                 aw_pend;
  logic                 w_pend;
  logic [BANK_BITS-1:0] wr_bank;
  mem_pkg::addr_t       wr_addr;
  mem_pkg::data_t       wr_data;
  mem_pkg::strb_t       wr_strb;
  logic                 rd_busy;
  logic                 ar_pend;
  logic [BANK_BITS-1:0] rd_bank;
  mem_pkg::addr_t       rd_addr;
  logic                 wr_take;
  logic                 rd_take;
  logic                 aw_hs;
  logic                 w_hs;
  logic                 ar_hs;

  function automatic logic [BANK_BITS-1:0] bank_of(input mem_pkg::addr_t a);
    mem_pkg::addr_t w;
    w = mem_pkg::word_addr(a);
    return w[BANK_BITS-1:0];
  endfunction

  // Bank-local byte address; bits above the memory size drop out here
  function automatic mem_pkg::addr_t local_addr(input mem_pkg::addr_t a);
    mem_pkg::addr_t w;
    w = mem_pkg::word_addr(a);
    return mem_pkg::addr_t'(w[BANK_BITS +: IDX_BITS]) << mem_pkg::BYTE_OFFSET;
  endfunction

  // --------------------------------------------------------------------------
  // Master side
  // --------------------------------------------------------------------------
  assign o_awready = ~wr_busy;
  assign o_wready  = ~wr_busy;
  assign o_arready = ~rd_busy;
  assign wr_take   = i_awvalid & i_wvalid & ~wr_busy;
  assign rd_take   = i_arvalid & ~rd_busy;

  // Bank side, valid only toward the decoded bank
  assign o_bank_awvalid = aw_pend ? (BANK0 << wr_bank) : '0;
  assign o_bank_wvalid  = w_pend ? (BANK0 << wr_bank) : '0;
  assign o_bank_arvalid = ar_pend ? (BANK0 << rd_bank) : '0;
  assign o_bank_awaddr  = wr_addr;
  assign o_bank_wdata   = wr_data;
  assign o_bank_wstrb   = wr_strb;
  assign o_bank_araddr  = rd_addr;

  assign aw_hs = |(o_bank_awvalid & i_bank_awready);
  assign w_hs  = |(o_bank_wvalid & i_bank_wready);
  assign ar_hs = |(o_bank_arvalid & i_bank_arready);

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_busy <= 1'b0;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      rd_busy <= 1'b0;
      ar_pend <= 1'b0;
    end else begin
      if (wr_take) begin
        wr_busy <= 1'b1;
        aw_pend <= 1'b1;
        w_pend  <= 1'b1;
      end else begin
        if (aw_hs) begin
          aw_pend <= 1'b0;
        end
        if (w_hs) begin
          w_pend <= 1'b0;
        end
        // Channel reopens once B has reached the master
        if (i_wr_done) begin
          wr_busy <= 1'b0;
        end
      end
      if (rd_take) begin
        rd_busy <= 1'b1;
        ar_pend <= 1'b1;
      end else begin
        if (ar_hs) begin
          ar_pend <= 1'b0;
        end
        if (i_rd_done) begin
          rd_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (wr_take) begin
      wr_bank <= bank_of(i_awaddr);
      wr_addr <= local_addr(i_awaddr);
      wr_data <= i_wdata;
      wr_strb <= i_wstrb;
    end
    if (rd_take) begin
      rd_bank <= bank_of(i_araddr);
      rd_addr <= local_addr(i_araddr);
    end
  end

  // A done pulse only follows a request that has reached its bank
  a_done_after_req: assert property (@(posedge i_aclk) disable iff (i_rst)
    (!i_wr_done || (wr_busy && !aw_pend && !w_pend)) &&
    (!i_rd_done || (rd_busy && !ar_pend)));

endmodule

// File: design/axil_sram_bank.sv
// Takes a bank-local byte address; one write and one read at a time, responses always OKAY
`timescale 1ns/10ps

module axil_sram_bank #(
  parameter int BANK_DEPTH = 64
) (
  input  logic           i_aclk,
  input  logic           i_rst,

  // Write address
  input  logic           i_awvalid,
  output logic           o_awready,
  input  mem_pkg::addr_t i_awaddr,

  // Write data
  input  logic           i_wvalid,
  output logic           o_wready,
  input  mem_pkg::data_t i_wdata,
  input  mem_pkg::strb_t i_wstrb,

  // Write response
  output logic           o_bvalid,
  input  logic           i_bready,
  output mem_pkg::resp_t o_bresp,

  // Read address
  input  logic           i_arvalid,
  output logic           o_arready,
  input  mem_pkg::addr_t i_araddr,

  // Read data
  output logic           o_rvalid,
  input  logic           i_rready,
  output mem_pkg::data_t o_rdata,
  output mem_pkg::resp_t o_rresp
);

  localparam int IDX_BITS = $clog2(BANK_DEPTH);

  mem_pkg::wr_state_t  wr_state;
  mem_pkg::rd_state_t  rd_state;
  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] rd_idx;
  logic                aw_fire;
  logic                w_fire;
  logic                b_fire;
  logic                ar_fire;
  logic                r_fire;

  mem_pkg::data_t mem [BANK_DEPTH];

  // --------------------------------------------------------------------------
  // Handshakes
  // --------------------------------------------------------------------------
  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid & o_wready;
  assign b_fire  = o_bvalid & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid & i_rready;

  // Ready and valid come straight from the state
  assign o_awready = (wr_state == mem_pkg::WR_IDLE);
  assign o_wready  = (wr_state == mem_pkg::WR_DATA);
  assign o_bvalid  = (wr_state == mem_pkg::WR_RESP);
  assign o_arready = (rd_state == mem_pkg::RD_IDLE);
  assign o_rvalid  = (rd_state == mem_pkg::RD_DATA);
  assign o_bresp   = mem_pkg::RESP_OKAY;
  assign o_rresp   = mem_pkg::RESP_OKAY;

  assign rd_idx = i_araddr[mem_pkg::BYTE_OFFSET +: IDX_BITS];

  // --------------------------------------------------------------------------
  // Write machine
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      wr_state <= mem_pkg::WR_IDLE;
    end else begin
      case (wr_state)
        mem_pkg::WR_IDLE: begin
          if (aw_fire) begin
            wr_state <= mem_pkg::WR_DATA;
          end
        end
        mem_pkg::WR_DATA: begin
          if (w_fire) begin
            wr_state <= mem_pkg::WR_RESP;
          end
        end
        mem_pkg::WR_RESP: begin
          if (b_fire) begin
            wr_state <= mem_pkg::WR_IDLE;
          end
        end
        default: begin
          wr_state <= mem_pkg::WR_IDLE;
        end
      endcase
    end
  end

  // Word index held from AW until the data beat
  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      wr_idx <= i_awaddr[mem_pkg::BYTE_OFFSET +: IDX_BITS];
    end
  end

  // Only strobed bytes change
  always_ff @(posedge i_aclk) begin
    if (w_fire) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read machine
  // --------------------------------------------------------------------------
  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      rd_state <= mem_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        mem_pkg::RD_IDLE: begin
          if (ar_fire) begin
            rd_state <= mem_pkg::RD_DATA;
          end
        end
        mem_pkg::RD_DATA: begin
          if (r_fire) begin
            rd_state <= mem_pkg::RD_IDLE;
          end
        end
        default: begin
          rd_state <= mem_pkg::RD_IDLE;
        end
      endcase
    end
  end

  // Same-cycle write to this word is not seen, old contents come back
  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      o_rdata <= mem[rd_idx];
    end
  end

  // Requests stay valid and steady until this bank takes them
  a_w_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_wvalid && !o_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb));

  a_ar_hold: assert property (@(posedge i_aclk) disable iff (i_rst)
    i_arvalid && !o_arready |=> i_arvalid && $stable(i_araddr));

endmodule

// File: design/axil_resp_merge.sv
// Relies on at most one bank raising bvalid and one raising rvalid at any time
`timescale 1ns/10ps

module axil_resp_merge #(
  parameter int NUM_BANKS = 4
) (
  input  logic                                i_aclk,
  input  logic                                i_rst,
  input  logic [NUM_BANKS-1:0]                i_bank_bvalid,
  output logic [NUM_BANKS-1:0]                o_bank_bready,
  input  logic [NUM_BANKS-1:0]                i_bank_rvalid,
  output logic [NUM_BANKS-1:0]                o_bank_rready,
  input  logic [NUM_BANKS*mem_pkg::DATA_W-1:0] i_bank_rdata,
  output logic                                o_bvalid,
  input  logic                                i_bready,
  output mem_pkg::resp_t                      o_bresp,
  output logic                                o_rvalid,
  input  logic                                i_rready,
  output mem_pkg::data_t                      o_rdata,
  output mem_pkg::resp_t                      o_rresp,
  output logic                                o_wr_done,
  output logic                                o_rd_done
);

  localparam int DW = mem_pkg::DATA_W;

  logic           b_full;
  logic           r_full;
  logic           b_take;
  logic           r_take;
  mem_pkg::data_t r_data;
  mem_pkg::data_t sel_rdata;

  // Banks only see ready while the output register is empty
  assign o_bank_bready = {NUM_BANKS{~b_full}};
  assign o_bank_rready = {NUM_BANKS{~r_full}};
  assign b_take        = (|i_bank_bvalid) & ~b_full;
  assign r_take        = (|i_bank_rvalid) & ~r_full;

  assign o_bvalid  = b_full;
  assign o_bresp   = mem_pkg::RESP_OKAY;
  assign o_rvalid  = r_full;
  assign o_rdata   = r_data;
  assign o_rresp   = mem_pkg::RESP_OKAY;
  assign o_wr_done = b_full & i_bready;
  assign o_rd_done = r_full & i_rready;

  // One-hot select of the responding bank
  always_comb begin
    sel_rdata = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (i_bank_rvalid[i]) begin
        sel_rdata = i_bank_rdata[i*DW +: DW];
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (i_rst) begin
      b_full <= 1'b0;
      r_full <= 1'b0;
    end else begin
      if (b_take) begin
        b_full <= 1'b1;
      end else if (o_wr_done) begin
        b_full <= 1'b0;
      end
      if (r_take) begin
        r_full <= 1'b1;
      end else if (o_rd_done) begin
        r_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_take) begin
      r_data <= sel_rdata;
    end
  end

  a_single_resp: assert property (@(posedge i_aclk) disable iff (i_rst)
    $onehot0(i_bank_bvalid) && $onehot0(i_bank_rvalid));

endmodule

// File: design/axil_banked_sram.sv
// Word-interleaved banks; addresses alias modulo NUM_BANKS*BANK_DEPTH words, no PROT
`timescale 1ns/10ps

module axil_banked_sram #(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 64
) (
  input  logic           i_aclk,
  input  logic           i_rst,
  input  logic           i_awvalid,
  output logic           o_awready,
  input  mem_pkg::addr_t i_awaddr,
  input  logic           i_wvalid,
  output logic           o_wready,
  input  mem_pkg::data_t i_wdata,
  input  mem_pkg::strb_t i_wstrb,
  output logic           o_bvalid,
  input  logic           i_bready,
  output mem_pkg::resp_t o_bresp,
  input  logic           i_arvalid,
  output logic           o_arready,
  input  mem_pkg::addr_t i_araddr,
  output logic           o_rvalid,
  input  logic           i_rready,
  output mem_pkg::data_t o_rdata,
  output mem_pkg::resp_t o_rresp
);

  localparam int DW = mem_pkg::DATA_W;

  logic [NUM_BANKS-1:0]    bank_awvalid;
  logic [NUM_BANKS-1:0]    bank_awready;
  logic [NUM_BANKS-1:0]    bank_wvalid;
  logic [NUM_BANKS-1:0]    bank_wready;
  logic [NUM_BANKS-1:0]    bank_arvalid;
  logic [NUM_BANKS-1:0]    bank_arready;
  logic [NUM_BANKS-1:0]    bank_bvalid;
  logic [NUM_BANKS-1:0]    bank_bready;
  logic [NUM_BANKS-1:0]    bank_rvalid;
  logic [NUM_BANKS-1:0]    bank_rready;
  logic [NUM_BANKS*DW-1:0] bank_rdata;
  mem_pkg::addr_t          bank_awaddr;
  mem_pkg::data_t          bank_wdata;
  mem_pkg::strb_t          bank_wstrb;
  mem_pkg::addr_t          bank_araddr;
  logic                    wr_done;
  logic                    rd_done;

  axil_bank_router #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) u_router (
    .i_aclk         (i_aclk),
    .i_rst          (i_rst),
    .i_awvalid      (i_awvalid),
    .o_awready      (o_awready),
    .i_awaddr       (i_awaddr),
    .i_wvalid       (i_wvalid),
    .o_wready       (o_wready),
    .i_wdata        (i_wdata),
    .i_wstrb        (i_wstrb),
    .i_arvalid      (i_arvalid),
    .o_arready      (o_arready),
    .i_araddr       (i_araddr),
    .o_bank_awvalid (bank_awvalid),
    .i_bank_awready (bank_awready),
    .o_bank_awaddr  (bank_awaddr),
    .o_bank_wvalid  (bank_wvalid),
    .i_bank_wready  (bank_wready),
    .o_bank_wdata   (bank_wdata),
    .o_bank_wstrb   (bank_wstrb),
    .o_bank_arvalid (bank_arvalid),
    .i_bank_arready (bank_arready),
    .o_bank_araddr  (bank_araddr),
    .i_wr_done      (wr_done),
    .i_rd_done      (rd_done)
  );

  // --------------------------------------------------------------------------
  // Banks, sharing address and data, each with its own valid and ready
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
    axil_sram_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .i_aclk    (i_aclk),
      .i_rst     (i_rst),
      .i_awvalid (bank_awvalid[g]),
      .o_awready (bank_awready[g]),
      .i_awaddr  (bank_awaddr),
      .i_wvalid  (bank_wvalid[g]),
      .o_wready  (bank_wready[g]),
      .i_wdata   (bank_wdata),
      .i_wstrb   (bank_wstrb),
      .o_bvalid  (bank_bvalid[g]),
      .i_bready  (bank_bready[g]),
      .o_bresp   (),
      .i_arvalid (bank_arvalid[g]),
      .o_arready (bank_arready[g]),
      .i_araddr  (bank_araddr),
      .o_rvalid  (bank_rvalid[g]),
      .i_rready  (bank_rready[g]),
      .o_rdata   (bank_rdata[g*DW +: DW]),
      .o_rresp   ()
    );
  end

  axil_resp_merge #(
    .NUM_BANKS (NUM_BANKS)
  ) u_merge (
    .i_aclk        (i_aclk),
    .i_rst         (i_rst),
    .i_bank_bvalid (bank_bvalid),
    .o_bank_bready (bank_bready),
    .i_bank_rvalid (bank_rvalid),
    .o_bank_rready (bank_rready),
    .i_bank_rdata  (bank_rdata),
    .o_bvalid      (o_bvalid),
    .i_bready      (i_bready),
    .o_bresp       (o_bresp),
    .o_rvalid      (o_rvalid),
    .i_rready      (i_rready),
    .o_rdata       (o_rdata),
    .o_rresp       (o_rresp),
    .o_wr_done     (wr_done),
    .o_rd_done     (rd_done)
  );

endmodule

// File: bench/sram_checker.sv
// Responses are matched in order per channel against expectations queued before each request
`timescale 1ns/10ps

module sram_checker (
  input  logic           i_aclk,
  input  logic           i_rst,
  input  logic           i_bvalid,
  input  logic           i_bready,
  input  mem_pkg::resp_t i_bresp,
  input  logic           i_rvalid,
  input  logic           i_rready,
  input  mem_pkg::data_t i_rdata,
  input  mem_pkg::resp_t i_rresp
);

  string          wr_names[$];
  string          rd_names[$];
  mem_pkg::data_t rd_exp[$];
  string          name;
  mem_pkg::data_t exp;
  int             pass_cnt = 0;
  int             err_cnt  = 0;
  logic           prev_rst = 1'b0;
  logic           b_stall  = 1'b0;
  logic           r_stall  = 1'b0;
  mem_pkg::resp_t b_held;
  mem_pkg::data_t r_held;

  task automatic expect_write(input string tname);
    wr_names.push_back(tname);
  endtask

  task automatic expect_read(input string tname, input mem_pkg::data_t data);
    rd_names.push_back(tname);
    rd_exp.push_back(data);
  endtask

  function automatic int outstanding();
    return wr_names.size() + rd_names.size();
  endfunction

  always @(posedge i_aclk) begin
    // Both valids must be low on the first edge out of reset
    if (prev_rst && !i_rst) begin
      if (i_bvalid !== 1'b0 || i_rvalid !== 1'b0) begin
        $display("After reset: bvalid or rvalid is not low");
        err_cnt++;
      end else begin
        $display("%-20s ok", "reset_valids_low");
        pass_cnt++;
      end
    end
    prev_rst <= i_rst;

    if (i_rst) begin
      b_stall <= 1'b0;
      r_stall <= 1'b0;
    end else begin
      // ----------------------------------------------------------------------
      // Hold rules under back-pressure
      // ----------------------------------------------------------------------
      if (b_stall && (!i_bvalid || i_bresp !== b_held)) begin
        $display("Write response dropped or changed while bready was low");
        err_cnt++;
      end
      if (r_stall && (!i_rvalid || i_rdata !== r_held)) begin
        $display("Read data dropped or changed while rready was low");
        err_cnt++;
      end
      b_stall <= i_bvalid && !i_bready;
      b_held  <= i_bresp;
      r_stall <= i_rvalid && !i_rready;
      r_held  <= i_rdata;

      // ----------------------------------------------------------------------
      // Completed handshakes
      // ----------------------------------------------------------------------
      if (i_bvalid && i_bready) begin
        if (wr_names.size() == 0) begin
          $display("Write response arrived with no write outstanding");
          err_cnt++;
        end else begin
          name = wr_names.pop_front();
          if (i_bresp !== mem_pkg::RESP_OKAY) begin
            $display("Mismatch %s: expected bresp %0h, actual %0h",
                     name, mem_pkg::RESP_OKAY, i_bresp);
            err_cnt++;
          end else begin
            $display("%-20s ok", name);
            pass_cnt++;
          end
        end
      end
      if (i_rvalid && i_rready) begin
        if (rd_names.size() == 0) begin
          $display("Read response arrived with no read outstanding");
          err_cnt++;
        end else begin
          name = rd_names.pop_front();
          exp  = rd_exp.pop_front();
          if (i_rdata !== exp) begin
            $display("Mismatch %s: expected %08h, actual %08h", name, exp, i_rdata);
            err_cnt++;
          end else if (i_rresp !== mem_pkg::RESP_OKAY) begin
            $display("Mismatch %s: expected rresp %0h, actual %0h",
                     name, mem_pkg::RESP_OKAY, i_rresp);
            err_cnt++;
          end else begin
            $display("%-20s ok", name);
            pass_cnt++;
          end
        end
      end
    end
  end

endmodule

// File: bench/tb_banked_sram.sv
// Run from the project root; the stimulus data assumes 4 banks of 64 words
`timescale 1ns/10ps

module tb_banked_sram;

  localparam int          NUM_BANKS  = 4;
  localparam int          BANK_DEPTH = 64;
  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] SEED       = 32'hfb1eaafc;
  localparam              STIM_FILE  = "bench/sram_stimulus.txt";

  logic           aclk;
  logic           rst;
  logic           awvalid;
  logic           awready;
  mem_pkg::addr_t awaddr;
  logic           wvalid;
  logic           wready;
  mem_pkg::data_t wdata;
  mem_pkg::strb_t wstrb;
  logic           bvalid;
  logic           bready = 1'b0;
  mem_pkg::resp_t bresp;
  logic           arvalid;
  logic           arready;
  mem_pkg::addr_t araddr;
  logic           rvalid;
  logic           rready = 1'b0;
  mem_pkg::data_t rdata;
  mem_pkg::resp_t rresp;
  logic [31:0]    lfsr   = SEED;
  logic [31:0]    lfsr_one;
  logic [31:0]    lfsr_two;
  logic           timed_out;
  logic           file_err;

  axil_banked_sram #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) uut (
    .i_aclk (aclk), .i_rst (rst),
    .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
    .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata), .i_wstrb (wstrb),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
    .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp)
  );

  sram_checker u_check (
    .i_aclk (aclk), .i_rst (rst),
    .i_bvalid (bvalid), .i_bready (bready), .i_bresp (bresp),
    .i_rvalid (rvalid), .i_rready (rready), .i_rdata (rdata), .i_rresp (rresp)
  );

  initial aclk = 1'b0;
  always #5 aclk = ~aclk;

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One step per ready bit
  assign lfsr_one = lfsr_step(lfsr);
  assign lfsr_two = lfsr_step(lfsr_one);

  always @(posedge aclk) begin
    if (rst) begin
      bready <= 1'b0;
      rready <= 1'b0;
    end else begin
      bready <= lfsr_one[0];
      rready <= lfsr_two[0];
      lfsr   <= lfsr_two;
    end
  end

  // --------------------------------------------------------------------------
  // Master driver
  // --------------------------------------------------------------------------
  task automatic do_write(input mem_pkg::addr_t addr, input mem_pkg::data_t data,
                          input mem_pkg::strb_t strb, input string name);
    int   n;
    logic done;
    u_check.expect_write(name);
    @(posedge aclk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
      done = awready && wready;
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    n    = 0;
    while (done && !(bvalid && bready) && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (!done || n >= TIMEOUT) begin
      $display("Timeout: write %s did not complete", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic do_read(input mem_pkg::addr_t addr, input mem_pkg::data_t exp,
                         input string name);
    int   n;
    logic done;
    u_check.expect_read(name, exp);
    @(posedge aclk);
    arvalid <= 1'b1;
    araddr  <= addr;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
      done = arready;
    end
    arvalid <= 1'b0;
    n    = 0;
    while (done && !(rvalid && rready) && n < TIMEOUT) begin
      @(posedge aclk);
      n++;
    end
    if (!done || n >= TIMEOUT) begin
      $display("Timeout: read %s did not complete", name);
      timed_out = 1'b1;
    end
  endtask

  initial begin
    int             fd;
    int             cnt;
    string          line;
    string          op;
    string          name;
    string          p_name;
    mem_pkg::addr_t addr;
    mem_pkg::data_t data;
    mem_pkg::strb_t strb;
    mem_pkg::data_t exp;
    mem_pkg::addr_t p_addr;
    mem_pkg::data_t p_data;
    mem_pkg::strb_t p_strb;
    logic           have_pair;
    rst       = 1'b1;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    arvalid   = 1'b0;
    araddr    = '0;
    timed_out = 1'b0;
    file_err  = 1'b0;
    have_pair = 1'b0;
    repeat (3) @(posedge aclk);
    rst <= 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open stimulus file %s", STIM_FILE);
      file_err = 1'b1;
    end else begin
      while (!timed_out && !$feof(fd)) begin
        if ($fgets(line, fd) == 0) continue;
        if (line.len() < 2 || line.getc(0) == "#") continue;
        cnt = $sscanf(line, "%s %h %h %h %h %s", op, addr, data, strb, exp, name);
        if (cnt != 6) begin
          $display("Malformed stimulus line: %s", line);
          file_err = 1'b1;
        end else if (op == "p") begin
          // Held back and issued together with the next read
          p_addr    = addr;
          p_data    = data;
          p_strb    = strb;
          p_name    = name;
          have_pair = 1'b1;
        end else if (op == "r" && have_pair) begin
          fork
            do_write(p_addr, p_data, p_strb, p_name);
            do_read(addr, exp, name);
          join
          have_pair = 1'b0;
        end else if (op == "r") begin
          do_read(addr, exp, name);
        end else if (op == "w") begin
          do_write(addr, data, strb, name);
        end else begin
          $display("Unknown operation %s in stimulus file", op);
          file_err = 1'b1;
        end
      end
      $fclose(fd);
    end
    if (have_pair) begin
      $display("Paired write %s has no read after it", p_name);
      file_err = 1'b1;
    end
    repeat (4) @(posedge aclk);
    if (u_check.outstanding() != 0) begin
      $display("%0d responses never arrived", u_check.outstanding());
    end
    $display("Tests passed: %0d, failed: %0d", u_check.pass_cnt, u_check.err_cnt);
    if (timed_out || file_err || u_check.err_cnt != 0 || u_check.outstanding() != 0 ||
        u_check.pass_cnt == 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule

// File: bench/sram_stimulus.txt
# op addr data strb expect name; hex fields, expect is checked on reads only
# op: w write, r read, p write issued together with the read on the next line
w 00000000 11111111 f 00000000 wr_bank0
w 00000004 22222222 f 00000000 wr_bank1
w 00000008 33333333 f 00000000 wr_bank2
w 0000000c 44444444 f 00000000 wr_bank3
r 00000000 00000000 0 11111111 rd_bank0
r 00000004 00000000 0 22222222 rd_bank1
r 00000008 00000000 0 33333333 rd_bank2
r 0000000c 00000000 0 44444444 rd_bank3
w 00000010 a5a5a5a5 f 00000000 wr_full_word4
w 00000010 0000cc00 2 00000000 wr_strb_byte1
r 00000010 00000000 0 a5a5cca5 rd_strb_byte1
w 00000010 ee0000dd 9 00000000 wr_strb_bytes03
r 00000010 00000000 0 eea5ccdd rd_strb_bytes03
p 00000018 55667788 f 00000000 wr_pair_bank2
r 0000000c 00000000 0 44444444 rd_pair_bank3
r 00000018 00000000 0 55667788 rd_after_pair
p 00000008 99999999 f 00000000 wr_pair_same
r 00000008 00000000 0 33333333 rd_pair_same_old
r 00000008 00000000 0 99999999 rd_pair_same_new
w 00000414 0badf00d f 00000000 wr_alias_high
r 00000014 00000000 0 0badf00d rd_alias_low
r 00000400 00000000 0 11111111 rd_alias_word0
r 80000414 00000000 0 0badf00d rd_alias_top_bit

// File: src.f
design/mem_pkg.sv
design/axil_bank_router.sv
design/axil_sram_bank.sv
design/axil_resp_merge.sv
design/axil_banked_sram.sv
bench/sram_checker.sv
bench/tb_banked_sram.sv

// File: Makefile
# Verilator flow for the banked AXI-lite SRAM

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
TOP       ?= tb_banked_sram
RTL_TOP   ?= axil_banked_sram
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
